/* flist.f */
src/fetchPkg.sv
src/btb.sv
src/branchPredictor.sv
src/returnStack.sv
src/nextPcLogic.sv
src/fetchStage1.sv
sim/fetchStage1Tb.sv

/* Makefile */
# Verilator build and run of the fetch stage testbench

VERILATOR ?= verilator
TOP       ?= fetchStage1Tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* sim/fetchStage1Tb.sv */
`timescale 1ns/1ns

module fetchStage1Tb;

    localparam int FetchWidth  = 2;
    localparam int BtbEntries  = 16;
    localparam int CntEntries  = 64;
    localparam int RasDepth    = 8;
    localparam int ClkPeriod   = 100;
    localparam int ResetCycles = 3;
    localparam int NumCycles   = 2000;
    localparam logic [31:0]  Seed    = 32'he84c_7d1d;
    localparam fetchPkg::pcT StartPc = 32'h0000_1000;

    // dut inputs
    logic               clk;
    logic               reset;
    logic               resetFetch;
    logic               stall;
    logic               recoverFlag;
    fetchPkg::pcT       recoverPc;
    logic               fs2RecoverFlag;
    fetchPkg::pcT       fs2RecoverPc;
    logic               fs2MissedCall;
    fetchPkg::pcT       fs2CallPc;
    logic               fs2MissedReturn;
    fetchPkg::pcT       startPc;
    logic               updateEn;
    fetchPkg::pcT       updatePc;
    fetchPkg::pcT       updateNpc;
    fetchPkg::ctrlTypeT updateBrType;
    logic               updateDir;
    fetchPkg::counterT  updateCounter;
    fetchPkg::instT     inst      [FetchWidth];
    logic               instValid [FetchWidth];

    // dut outputs
    logic               fetchReq;
    fetchPkg::pcT       instPc      [FetchWidth];
    logic               fs1Ready;
    fetchPkg::pcT       addrRas;
    fetchPkg::instT     pktInst     [FetchWidth];
    logic               pktBtbHit   [FetchWidth];
    fetchPkg::ctrlTypeT pktCtrlType [FetchWidth];
    fetchPkg::pcT       pktTakenPc  [FetchWidth];
    logic               pktPredDir  [FetchWidth];
    fetchPkg::counterT  predCounter [FetchWidth];
    logic               pktValid    [FetchWidth];

    // reference model state
    logic               mBtbValid  [BtbEntries];
    fetchPkg::pcT       mBtbTag    [BtbEntries];
    fetchPkg::pcT       mBtbTarget [BtbEntries];
    fetchPkg::ctrlTypeT mBtbType   [BtbEntries];
    fetchPkg::counterT  mCnt       [CntEntries];
    fetchPkg::pcT       mStack     [RasDepth];
    int                 mPtr;
    fetchPkg::pcT       mPc;
    logic               mFetchReq;

    // per-lane lookups of the model and its prediction
    logic               expHit    [FetchWidth];
    fetchPkg::pcT       expTarget [FetchWidth];
    fetchPkg::ctrlTypeT expType   [FetchWidth];
    fetchPkg::counterT  expCnt    [FetchWidth];
    fetchPkg::pcT       predNpc;
    fetchPkg::pcT       predPushAddr;
    logic               predPush;
    logic               predPop;

    logic [31:0] rngState;

    always #(ClkPeriod / 2) clk = ~clk;

    fetchStage1 #(
        .FetchWidth (FetchWidth),
        .BtbEntries (BtbEntries),
        .CntEntries (CntEntries),
        .RasDepth   (RasDepth)
    ) fetchStage1_i (
        .clk               (clk),
        .reset             (reset),
        .resetFetch_i      (resetFetch),
        .stall_i           (stall),
        .recoverFlag_i     (recoverFlag),
        .recoverPc_i       (recoverPc),
        .fs2RecoverFlag_i  (fs2RecoverFlag),
        .fs2RecoverPc_i    (fs2RecoverPc),
        .fs2MissedCall_i   (fs2MissedCall),
        .fs2CallPc_i       (fs2CallPc),
        .fs2MissedReturn_i (fs2MissedReturn),
        .startPc_i         (startPc),
        .updateEn_i        (updateEn),
        .updatePc_i        (updatePc),
        .updateNpc_i       (updateNpc),
        .updateBrType_i    (updateBrType),
        .updateDir_i       (updateDir),
        .updateCounter_i   (updateCounter),
        .inst_i            (inst),
        .instValid_i       (instValid),
        .fetchReq_o        (fetchReq),
        .instPc_o          (instPc),
        .fs1Ready_o        (fs1Ready),
        .addrRas_o         (addrRas),
        .pktInst_o         (pktInst),
        .pktBtbHit_o       (pktBtbHit),
        .pktCtrlType_o     (pktCtrlType),
        .pktTakenPc_o      (pktTakenPc),
        .pktPredDir_o      (pktPredDir),
        .predCounter_o     (predCounter),
        .pktValid_o        (pktValid)
    );

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        abortRun($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic checkPc(input string name, input fetchPkg::pcT got, input fetchPkg::pcT exp);
        if (got !== exp)
            reportMismatch(name, got, exp);
    endtask

    task automatic checkInst(input string name, input fetchPkg::instT got,
                             input fetchPkg::instT exp);
        if (got !== exp)
            reportMismatch(name, got, exp);
    endtask

    task automatic checkCtrl(input string name, input fetchPkg::ctrlTypeT got,
                             input fetchPkg::ctrlTypeT exp);
        if (got !== exp)
            reportMismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic checkCounter(input string name, input fetchPkg::counterT got,
                                input fetchPkg::counterT exp);
        if (got !== exp)
            reportMismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp)
            reportMismatch(name, 32'(got), 32'(exp));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;

        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic drawRandom(output logic [31:0] r);
        rngState = xorshift32(rngState);
        r = rngState;
    endtask

    // word address modulo table size
    function automatic int btbIndex(input fetchPkg::pcT a);
        return int'((a / fetchPkg::InstBytes) % BtbEntries);
    endfunction

    function automatic int cntIndex(input fetchPkg::pcT a);
        return int'((a / fetchPkg::InstBytes) % CntEntries);
    endfunction

    // one step toward the outcome
    // held at 0 and 3
    function automatic fetchPkg::counterT stepCounter(input fetchPkg::counterT c, input logic dir);
        if (dir)
            return (c == 2'd3) ? 2'd3 : c + 2'd1;
        return (c == 2'd0) ? 2'd0 : c - 2'd1;
    endfunction

    // aligned words just above the start pc
    function automatic fetchPkg::pcT poolAddr(input logic [4:0] k);
        return StartPc + fetchPkg::pcT'(fetchPkg::InstBytes * int'(k));
    endfunction

    task automatic clearModel();
        for (int e = 0; e < BtbEntries; e++)
        begin
            mBtbValid[e]  = 1'b0;
            mBtbTag[e]    = '0;
            mBtbTarget[e] = '0;
            mBtbType[e]   = fetchPkg::ctrlJump;
        end
        for (int e = 0; e < CntEntries; e++)
            mCnt[e] = 2'd1;
        for (int e = 0; e < RasDepth; e++)
            mStack[e] = '0;
        mPtr = 0;
    endtask

    // circular stack where overflow drops the oldest
    task automatic pushModel(input fetchPkg::pcT a);
        mPtr = (mPtr + 1) % RasDepth;
        mStack[mPtr] = a;
    endtask

    task automatic popModel();
        mPtr = (mPtr + RasDepth - 1) % RasDepth;
    endtask

    // lane lookups from model state and current inputs
    task automatic predictLanes();
        fetchPkg::pcT addr;
        int           winner;
        int           numValid;
        int           b;
        int           c;

        winner   = -1;
        numValid = 0;
        for (int i = 0; i < FetchWidth; i++)
        begin
            addr         = mPc + fetchPkg::pcT'(fetchPkg::InstBytes * i);
            b            = btbIndex(addr);
            c            = cntIndex(addr);
            expHit[i]    = mBtbValid[b] && (mBtbTag[b] == addr);
            expTarget[i] = mBtbTarget[b];
            expType[i]   = mBtbType[b];
            expCnt[i]    = mCnt[c];
            if (instValid[i])
                numValid++;
            // first taken lane in lane order
            if (winner < 0 && instValid[i] && expHit[i]
                && (expCnt[i] >= 2'd2 || expType[i] != fetchPkg::ctrlCondBranch))
                winner = i;
        end
        predPush     = 1'b0;
        predPop      = 1'b0;
        predPushAddr = '0;
        if (winner < 0)
            predNpc = mPc + fetchPkg::pcT'(fetchPkg::InstBytes * numValid);
        else if (expType[winner] == fetchPkg::ctrlReturn)
        begin
            predNpc = mStack[mPtr];
            predPop = 1'b1;
        end
        else
        begin
            predNpc = expTarget[winner];
            if (expType[winner] == fetchPkg::ctrlCall)
            begin
                predPush     = 1'b1;
                predPushAddr = mPc + fetchPkg::pcT'(fetchPkg::InstBytes * (winner + 1));
            end
        end
    endtask

    // model state after the clock edge
    task automatic advanceModel();
        fetchPkg::pcT nextPc;
        int           b;

        if (reset)
        begin
            clearModel();
            mPc       = StartPc;
            mFetchReq = 1'b0;
        end
        else
        begin
            predictLanes();
            mFetchReq = !resetFetch;
            if (resetFetch)
            begin
                clearModel();
                mPc = StartPc;
            end
            else
            begin
                nextPc = mPc;
                if (recoverFlag)
                    nextPc = recoverPc;
                else if (fs2RecoverFlag)
                begin
                    nextPc = fs2MissedReturn ? mStack[mPtr] : fs2RecoverPc;
                    if (fs2MissedCall)
                        pushModel(fs2CallPc);
                    else if (fs2MissedReturn)
                        popModel();
                end
                else if (!stall)
                begin
                    nextPc = predNpc;
                    if (predPush)
                        pushModel(predPushAddr);
                    else if (predPop)
                        popModel();
                end
                // table writes ignore stall and redirects
                if (updateEn && updateDir)
                begin
                    b             = btbIndex(updatePc);
                    mBtbValid[b]  = 1'b1;
                    mBtbTag[b]    = updatePc;
                    mBtbTarget[b] = updateNpc;
                    mBtbType[b]   = updateBrType;
                end
                if (updateEn && updateBrType == fetchPkg::ctrlCondBranch)
                    mCnt[cntIndex(updatePc)] = stepCounter(updateCounter, updateDir);
                mPc = nextPc;
            end
        end
    endtask

    task automatic driveRandom();
        logic [31:0] r;

        drawRandom(r);
        // stall 1 in 4 and rare redirects
        stall           <= (r[1:0] == 2'd0);
        recoverFlag     <= (r[6:2] == 5'd0);
        fs2RecoverFlag  <= (r[11:7] == 5'd0);
        resetFetch      <= (r[18:12] == 7'd0);
        fs2MissedCall   <= (r[20:19] == 2'd1);
        fs2MissedReturn <= (r[20:19] == 2'd2);
        updateEn        <= r[21];
        updateDir       <= (r[23:22] != 2'd0);
        updateCounter   <= r[25:24];
        updateBrType    <= fetchPkg::ctrlTypeT'(r[27:26]);
        drawRandom(r);
        // half the updates train the lanes being fetched
        if (r[0])
            updatePc <= mPc + fetchPkg::pcT'(fetchPkg::InstBytes * int'(r[3:1]));
        else
            updatePc <= poolAddr(r[8:4]);
        updateNpc    <= poolAddr(r[13:9]);
        recoverPc    <= poolAddr(r[18:14]);
        fs2RecoverPc <= poolAddr(r[23:19]);
        fs2CallPc    <= poolAddr(r[28:24]);
        for (int i = 0; i < FetchWidth; i++)
        begin
            drawRandom(r);
            inst[i]      <= r;
            instValid[i] <= (r[2:0] != 3'd0);
        end
    endtask

    task automatic checkOutputs();
        fetchPkg::instT expInst;
        fetchPkg::pcT   expTaken;

        predictLanes();
        for (int i = 0; i < FetchWidth; i++)
        begin
            expInst  = instValid[i] ? inst[i] : '0;
            expTaken = (expType[i] == fetchPkg::ctrlReturn) ? mStack[mPtr] : expTarget[i];
            checkPc($sformatf("instPc_o[%0d]", i), instPc[i],
                    mPc + fetchPkg::pcT'(fetchPkg::InstBytes * i));
            checkInst($sformatf("pktInst_o[%0d]", i), pktInst[i], expInst);
            checkBit($sformatf("pktBtbHit_o[%0d]", i), pktBtbHit[i], expHit[i]);
            checkCtrl($sformatf("pktCtrlType_o[%0d]", i), pktCtrlType[i], expType[i]);
            checkPc($sformatf("pktTakenPc_o[%0d]", i), pktTakenPc[i], expTaken);
            checkBit($sformatf("pktPredDir_o[%0d]", i), pktPredDir[i], expCnt[i] >= 2'd2);
            checkCounter($sformatf("predCounter_o[%0d]", i), predCounter[i], expCnt[i]);
            checkBit($sformatf("pktValid_o[%0d]", i), pktValid[i], instValid[i]);
        end
        checkBit("fetchReq_o", fetchReq, mFetchReq);
        checkBit("fs1Ready_o", fs1Ready, instValid[0]);
        checkPc("addrRas_o", addrRas, mStack[mPtr]);
    endtask

    // ends a run that never reaches its last cycle
    initial
    begin
        #(ClkPeriod * (ResetCycles + NumCycles + 50));
        abortRun("timeout: the testbench did not finish its cycles in time");
    end

    initial
    begin
        rngState        = Seed;
        clk             = 1'b0;
        reset           = 1'b1;
        resetFetch      = 1'b0;
        stall           = 1'b0;
        recoverFlag     = 1'b0;
        recoverPc       = '0;
        fs2RecoverFlag  = 1'b0;
        fs2RecoverPc    = '0;
        fs2MissedCall   = 1'b0;
        fs2CallPc       = '0;
        fs2MissedReturn = 1'b0;
        startPc         = StartPc;
        updateEn        = 1'b0;
        updatePc        = '0;
        updateNpc       = '0;
        updateBrType    = fetchPkg::ctrlJump;
        updateDir       = 1'b0;
        updateCounter   = '0;
        for (int i = 0; i < FetchWidth; i++)
        begin
            inst[i]      = '0;
            instValid[i] = 1'b0;
        end
        clearModel();
        mPc       = StartPc;
        mFetchReq = 1'b0;

        // model steps on the edge and outputs get checked mid-cycle
        for (int cyc = 1; cyc <= ResetCycles + NumCycles; cyc++)
        begin
            @(posedge clk);
            advanceModel();
            if (cyc == ResetCycles)
                reset <= 1'b0;
            if (cyc >= ResetCycles)
                driveRandom();
            @(negedge clk);
            checkOutputs();
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* src/fetchStage1.sv */
`timescale 1ns/1ns

module fetchStage1 #(
    parameter int FetchWidth = 2,
    parameter int BtbEntries = 16,
    parameter int CntEntries = 64,
    parameter int RasDepth   = 8
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               resetFetch_i,
    input  logic               stall_i,
    input  logic               recoverFlag_i,
    input  fetchPkg::pcT       recoverPc_i,
    input  logic               fs2RecoverFlag_i,
    input  fetchPkg::pcT       fs2RecoverPc_i,
    input  logic               fs2MissedCall_i,
    input  fetchPkg::pcT       fs2CallPc_i,
    input  logic               fs2MissedReturn_i,
    input  fetchPkg::pcT       startPc_i,
    input  logic               updateEn_i,
    input  fetchPkg::pcT       updatePc_i,
    input  fetchPkg::pcT       updateNpc_i,
    input  fetchPkg::ctrlTypeT updateBrType_i,
    input  logic               updateDir_i,
    input  fetchPkg::counterT  updateCounter_i,
    input  fetchPkg::instT     inst_i        [FetchWidth],
    input  logic               instValid_i   [FetchWidth],
    output logic               fetchReq_o,
    output fetchPkg::pcT       instPc_o      [FetchWidth],
    output logic               fs1Ready_o,
    output fetchPkg::pcT       addrRas_o,
    output fetchPkg::instT     pktInst_o     [FetchWidth],
    output logic               pktBtbHit_o   [FetchWidth],
    output fetchPkg::ctrlTypeT pktCtrlType_o [FetchWidth],
    output fetchPkg::pcT       pktTakenPc_o  [FetchWidth],
    output logic               pktPredDir_o  [FetchWidth],
    output fetchPkg::counterT  predCounter_o [FetchWidth],
    output logic               pktValid_o    [FetchWidth]
);

    fetchPkg::pcT       pc;
    fetchPkg::pcT       rasTop;
    fetchPkg::pcT       rasPushAddr;
    fetchPkg::pcT       btbTarget [FetchWidth];
    fetchPkg::ctrlTypeT btbType   [FetchWidth];
    logic               btbHit    [FetchWidth];
    logic               predDir   [FetchWidth];
    logic               updateBtb;
    logic               updateBp;
    logic               rasPush;
    logic               rasPop;

    // btb learns only taken outcomes
    assign updateBtb = updateEn_i && updateDir_i;
    // counters track conditional branches only
    assign updateBp  = updateEn_i && (updateBrType_i == fetchPkg::ctrlCondBranch);

    btb #(
        .FetchWidth (FetchWidth),
        .BtbEntries (BtbEntries)
    ) btb_i (
        .clk            (clk),
        .reset          (reset),
        .clear_i        (resetFetch_i),
        .pc_i           (pc),
        .updateEn_i     (updateBtb),
        .updatePc_i     (updatePc_i),
        .updateNpc_i    (updateNpc_i),
        .updateBrType_i (updateBrType_i),
        .hit_o          (btbHit),
        .target_o       (btbTarget),
        .ctrlType_o     (btbType)
    );

    branchPredictor #(
        .FetchWidth (FetchWidth),
        .CntEntries (CntEntries)
    ) branchPredictor_i (
        .clk             (clk),
        .reset           (reset),
        .clear_i         (resetFetch_i),
        .pc_i            (pc),
        .updateEn_i      (updateBp),
        .updatePc_i      (updatePc_i),
        .updateDir_i     (updateDir_i),
        .updateCounter_i (updateCounter_i),
        .predDir_o       (predDir),
        .predCounter_o   (predCounter_o)
    );

    returnStack #(
        .RasDepth (RasDepth)
    ) returnStack_i (
        .clk        (clk),
        .reset      (reset),
        .clear_i    (resetFetch_i),
        .push_i     (rasPush),
        .pop_i      (rasPop),
        .pushAddr_i (rasPushAddr),
        .top_o      (rasTop)
    );

    nextPcLogic #(
        .FetchWidth (FetchWidth)
    ) nextPcLogic_i (
        .clk               (clk),
        .reset             (reset),
        .resetFetch_i      (resetFetch_i),
        .stall_i           (stall_i),
        .recoverFlag_i     (recoverFlag_i),
        .fs2RecoverFlag_i  (fs2RecoverFlag_i),
        .fs2MissedCall_i   (fs2MissedCall_i),
        .fs2MissedReturn_i (fs2MissedReturn_i),
        .startPc_i         (startPc_i),
        .recoverPc_i       (recoverPc_i),
        .fs2RecoverPc_i    (fs2RecoverPc_i),
        .fs2CallPc_i       (fs2CallPc_i),
        .instValid_i       (instValid_i),
        .hit_i             (btbHit),
        .predDir_i         (predDir),
        .ctrlType_i        (btbType),
        .target_i          (btbTarget),
        .rasTop_i          (rasTop),
        .pc_o              (pc),
        .fetchReq_o        (fetchReq_o),
        .rasPush_o         (rasPush),
        .rasPop_o          (rasPop),
        .rasPushAddr_o     (rasPushAddr)
    );

    // lane packets for the second fetch stage
    always_comb
    begin
        for (int i = 0; i < FetchWidth; i++)
        begin
            instPc_o[i]      = pc + fetchPkg::pcT'(fetchPkg::InstBytes * i);
            // invalid lanes send a zero word
            pktInst_o[i]     = instValid_i[i] ? inst_i[i] : '0;
            pktBtbHit_o[i]   = btbHit[i];
            pktCtrlType_o[i] = btbType[i];
            pktTakenPc_o[i]  = (btbType[i] == fetchPkg::ctrlReturn) ? rasTop : btbTarget[i];
            pktPredDir_o[i]  = predDir[i];
            pktValid_o[i]    = instValid_i[i];
        end
    end

    // bundle is usable when lane 0 is
    assign fs1Ready_o = instValid_i[0];
    assign addrRas_o  = rasTop;

endmodule

/* src/nextPcLogic.sv */
`timescale 1ns/1ns

module nextPcLogic #(
    parameter int FetchWidth = 2
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               resetFetch_i,
    input  logic               stall_i,
    input  logic               recoverFlag_i,
    input  logic               fs2RecoverFlag_i,
    input  logic               fs2MissedCall_i,
    input  logic               fs2MissedReturn_i,
    input  fetchPkg::pcT       startPc_i,
    input  fetchPkg::pcT       recoverPc_i,
    input  fetchPkg::pcT       fs2RecoverPc_i,
    input  fetchPkg::pcT       fs2CallPc_i,
    input  logic               instValid_i [FetchWidth],
    input  logic               hit_i       [FetchWidth],
    input  logic               predDir_i   [FetchWidth],
    input  fetchPkg::ctrlTypeT ctrlType_i  [FetchWidth],
    input  fetchPkg::pcT       target_i    [FetchWidth],
    input  fetchPkg::pcT       rasTop_i,
    output fetchPkg::pcT       pc_o,
    output logic               fetchReq_o,
    output logic               rasPush_o,
    output logic               rasPop_o,
    output fetchPkg::pcT       rasPushAddr_o
);

    fetchPkg::pcT pcQ;
    fetchPkg::pcT nextPc;
    fetchPkg::pcT predNpc;
    fetchPkg::pcT predPushAddr;
    logic         predPush;
    logic         predPop;
    logic         taken [FetchWidth];

    // taken lane needs valid and hit, plus predicted taken unless unconditional
    always_comb
    begin
        for (int i = 0; i < FetchWidth; i++)
            taken[i] = instValid_i[i] && hit_i[i]
                       && (predDir_i[i] || (ctrlType_i[i] != fetchPkg::ctrlCondBranch));
    end

    // predicted next pc and stack ops
    always_comb
    begin
        int numValid;

        numValid = 0;
        for (int i = 0; i < FetchWidth; i++)
            numValid = numValid + int'(instValid_i[i]);

        // fall through past the valid lanes
        predNpc      = pcQ + fetchPkg::pcT'(fetchPkg::InstBytes * numValid);
        predPush     = 1'b0;
        predPop      = 1'b0;
        predPushAddr = pcQ + fetchPkg::pcT'(fetchPkg::InstBytes);

        // scan high to low so the lowest taken lane lands last
        for (int i = FetchWidth - 1; i >= 0; i--)
        begin
            if (taken[i])
            begin
                predPop      = (ctrlType_i[i] == fetchPkg::ctrlReturn);
                predPush     = (ctrlType_i[i] == fetchPkg::ctrlCall);
                predNpc      = predPop ? rasTop_i : target_i[i];
                // return address is the lane after the call
                predPushAddr = pcQ + fetchPkg::pcT'(fetchPkg::InstBytes * (i + 1));
            end
        end
    end

    // redirect priority, stall holds the pc
    always_comb
    begin
        nextPc        = pcQ;
        rasPush_o     = 1'b0;
        rasPop_o      = 1'b0;
        rasPushAddr_o = predPushAddr;
        if (resetFetch_i)
            nextPc = startPc_i;
        else if (recoverFlag_i)
            // full recovery leaves the stack alone
            nextPc = recoverPc_i;
        else if (fs2RecoverFlag_i)
        begin
            nextPc        = fs2MissedReturn_i ? rasTop_i : fs2RecoverPc_i;
            rasPush_o     = fs2MissedCall_i;
            rasPop_o      = fs2MissedReturn_i;
            rasPushAddr_o = fs2CallPc_i;
        end
        else if (!stall_i)
        begin
            nextPc    = predNpc;
            rasPush_o = predPush;
            rasPop_o  = predPop;
        end
    end

    // pc register, loads start pc on reset
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            pcQ <= startPc_i;
        else
            pcQ <= nextPc;
    end

    // request low for one cycle after any reset
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            fetchReq_o <= 1'b0;
        else
            fetchReq_o <= !resetFetch_i;
    end

    assign pc_o = pcQ;

endmodule

/* src/returnStack.sv */
`timescale 1ns/1ns

module returnStack #(
    parameter int RasDepth = 8
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         clear_i,
    input  logic         push_i,
    input  logic         pop_i,
    input  fetchPkg::pcT pushAddr_i,
    output fetchPkg::pcT top_o
);

    localparam int PtrWidth = $clog2(RasDepth);

    typedef logic [PtrWidth-1:0] rasPtrT;

    fetchPkg::pcT stackQ [RasDepth];
    rasPtrT       ptrQ;
    rasPtrT       ptrUp;

    // slot above the pointer wraps around
    assign ptrUp = ptrQ + rasPtrT'(1);

    // top is the slot under the pointer
    assign top_o = stackQ[ptrQ];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            ptrQ <= '0;
            for (int e = 0; e < RasDepth; e++)
                stackQ[e] <= '0;
        end
        else if (clear_i)
        begin
            ptrQ <= '0;
            for (int e = 0; e < RasDepth; e++)
                stackQ[e] <= '0;
        end
        else if (push_i)
        begin
            // overflow overwrites the oldest entry
            stackQ[ptrUp] <= pushAddr_i;
            ptrQ          <= ptrUp;
        end
        else if (pop_i)
            // empty pop simply wraps
            ptrQ <= ptrQ - rasPtrT'(1);
    end

endmodule

/* src/branchPredictor.sv */
`timescale 1ns/1ns

module branchPredictor #(
    parameter int FetchWidth = 2,
    parameter int CntEntries = 64
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              clear_i,
    input  fetchPkg::pcT      pc_i,
    input  logic              updateEn_i,
    input  fetchPkg::pcT      updatePc_i,
    input  logic              updateDir_i,
    input  fetchPkg::counterT updateCounter_i,
    output logic              predDir_o     [FetchWidth],
    output fetchPkg::counterT predCounter_o [FetchWidth]
);

    localparam int IdxWidth = $clog2(CntEntries);
    localparam int ByteBits = $clog2(fetchPkg::InstBytes);

    typedef logic [IdxWidth-1:0] cntIdxT;

    fetchPkg::counterT cntQ [CntEntries];
    fetchPkg::counterT nextCnt;
    cntIdxT            updateIdx;

    assign updateIdx = updatePc_i[ByteBits +: IdxWidth];

    // step supplied counter toward the outcome, saturate at 0 and 3
    always_comb
    begin
        if (updateDir_i)
            nextCnt = (updateCounter_i == 2'd3) ? 2'd3 : updateCounter_i + 2'd1;
        else
            nextCnt = (updateCounter_i == 2'd0) ? 2'd0 : updateCounter_i - 2'd1;
    end

    // lane lookup, msb gives taken
    always_comb
    begin
        fetchPkg::pcT laneAddr;

        laneAddr = '0;
        for (int i = 0; i < FetchWidth; i++)
        begin
            laneAddr         = pc_i + fetchPkg::pcT'(fetchPkg::InstBytes * i);
            predCounter_o[i] = cntQ[laneAddr[ByteBits +: IdxWidth]];
            predDir_o[i]     = predCounter_o[i][1];
        end
    end

    // all counters start weakly not taken
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int e = 0; e < CntEntries; e++)
                cntQ[e] <= 2'd1;
        end
        else if (clear_i)
        begin
            for (int e = 0; e < CntEntries; e++)
                cntQ[e] <= 2'd1;
        end
        else if (updateEn_i)
            cntQ[updateIdx] <= nextCnt;
    end

endmodule

/* src/btb.sv */
`timescale 1ns/1ns

module btb #(
    parameter int FetchWidth = 2,
    parameter int BtbEntries = 16
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               clear_i,
    input  fetchPkg::pcT       pc_i,
    input  logic               updateEn_i,
    input  fetchPkg::pcT       updatePc_i,
    input  fetchPkg::pcT       updateNpc_i,
    input  fetchPkg::ctrlTypeT updateBrType_i,
    output logic               hit_o      [FetchWidth],
    output fetchPkg::pcT       target_o   [FetchWidth],
    output fetchPkg::ctrlTypeT ctrlType_o [FetchWidth]
);

    localparam int IdxWidth = $clog2(BtbEntries);
    // low address bits dropped before indexing
    localparam int ByteBits = $clog2(fetchPkg::InstBytes);

    typedef logic [IdxWidth-1:0] btbIdxT;

    // table contents, one entry per index
    logic               validQ  [BtbEntries];
    fetchPkg::pcT       tagQ    [BtbEntries];
    fetchPkg::pcT       targetQ [BtbEntries];
    fetchPkg::ctrlTypeT typeQ   [BtbEntries];

    btbIdxT updateIdx;

    // word address modulo table size
    assign updateIdx = updatePc_i[ByteBits +: IdxWidth];

    // per-lane lookup, old contents during a write
    always_comb
    begin
        fetchPkg::pcT laneAddr;
        btbIdxT       laneIdx;

        laneAddr = '0;
        laneIdx  = '0;
        for (int i = 0; i < FetchWidth; i++)
        begin
            laneAddr      = pc_i + fetchPkg::pcT'(fetchPkg::InstBytes * i);
            laneIdx       = laneAddr[ByteBits +: IdxWidth];
            // full lane address serves as tag
            hit_o[i]      = validQ[laneIdx] && (tagQ[laneIdx] == laneAddr);
            target_o[i]   = targetQ[laneIdx];
            ctrlType_o[i] = typeQ[laneIdx];
        end
    end

    // one write per update, emptied by either clear
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int e = 0; e < BtbEntries; e++)
            begin
                validQ[e]  <= 1'b0;
                tagQ[e]    <= '0;
                targetQ[e] <= '0;
                typeQ[e]   <= fetchPkg::ctrlJump;
            end
        end
        else if (clear_i)
        begin
            for (int e = 0; e < BtbEntries; e++)
            begin
                validQ[e]  <= 1'b0;
                tagQ[e]    <= '0;
                targetQ[e] <= '0;
                typeQ[e]   <= fetchPkg::ctrlJump;
            end
        end
        else if (updateEn_i)
        begin
            validQ[updateIdx]  <= 1'b1;
            tagQ[updateIdx]    <= updatePc_i;
            targetQ[updateIdx] <= updateNpc_i;
            typeQ[updateIdx]   <= updateBrType_i;
        end
    end

endmodule

/* src/fetchPkg.sv */
package fetchPkg;

    // address and instruction widths
    localparam int PcWidth   = 32;
    localparam int InstWidth = 32;

    // bytes covered by one fetch lane
    localparam int InstBytes = 4;

    // program counter or branch target
    typedef logic [PcWidth-1:0] pcT;

    // one raw instruction word
    typedef logic [InstWidth-1:0] instT;

    // two-bit direction counter
    // 0 and 1 predict not taken, 2 and 3 predict taken
    typedef logic [1:0] counterT;

    // kind of control instruction held in the btb
    // same encoding on the update port
    typedef enum logic [1:0] {
        ctrlJump       = 2'd0,
        ctrlCall       = 2'd1,
        ctrlReturn     = 2'd2,
        ctrlCondBranch = 2'd3
    } ctrlTypeT;

endpackage
